/* dv/key_extract_assert.sv */
// bound assertions for the key extract handshake and output stability
`timescale 1ns/100ps

module key_extract_assert (
    input logic          clk,
    input logic          rst_n,
    input logic          phv_valid_in,
    input logic          ready_out,
    input logic          phv_valid_out,
    input logic          key_valid_out,
    input phv_pkg::phv_t phv_out,
    input phv_pkg::key_t key_out_masked,
    input phv_pkg::key_t key_mask_out
);

    int fail_count = 0;

    valids_together: assert property (@(posedge clk) disable iff (!rst_n)
        phv_valid_out == key_valid_out)
    else begin
        $error("phv_valid_out and key_valid_out differ");
        fail_count++;
    end

    valid_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        phv_valid_out |=> !phv_valid_out)
    else begin
        $error("valid pulse lasted more than one cycle");
        fail_count++;
    end

    // ready_out may only come back together with the valid pulse
    ready_low_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        (!ready_out || phv_valid_in) |=> (!ready_out || phv_valid_out))
    else begin
        $error("ready_out rose before the valid pulse");
        fail_count++;
    end

    // four low samples of ready_out put the stage past key assembly
    outputs_held: assert property (@(posedge clk) disable iff (!rst_n)
        (!ready_out && $past(!ready_out) && $past(!ready_out, 2) && $past(!ready_out, 3))
        |-> ($stable(phv_out) && $stable(key_out_masked) && $stable(key_mask_out)))
    else begin
        $error("outputs changed while waiting on ready_in");
        fail_count++;
    end

endmodule

bind key_extract key_extract_assert u_key_extract_assert (.*);

/* dv/key_extract_tb.sv */
// testbench for the key extract stage with a reference model and directed tests
`timescale 1ns/100ps

module key_extract_tb;

    localparam int STAGE_ID = 2;
    localparam int CHK_W    = $bits(phv_pkg::phv_t);
    localparam int LIMIT    = 50;

    logic                     clk;
    logic                     rst_n;
    phv_pkg::phv_t            phv_in;
    logic                     phv_valid_in;
    logic                     ready_out;
    logic                     cfg_valid;
    key_cfg_pkg::cfg_write_t  cfg_in;
    phv_pkg::phv_t            phv_out;
    logic                     phv_valid_out;
    phv_pkg::key_t            key_out_masked;
    phv_pkg::key_t            key_mask_out;
    logic                     key_valid_out;
    logic                     ready_in;

    // model copies of the tenant tables
    key_cfg_pkg::key_offset_t ref_offset [key_cfg_pkg::TABLE_DEPTH];
    phv_pkg::key_t            ref_mask   [key_cfg_pkg::TABLE_DEPTH];
    int                       seed   = 19286;
    int                       errors = 0;

    key_extract #(.STAGE_ID(STAGE_ID)) UUT (.*);

    always #4 clk = ~clk;

    function automatic key_cfg_pkg::table_addr_t tenant_of(input phv_pkg::phv_t p);
        return p[phv_pkg::VLAN_LSB+7:phv_pkg::VLAN_LSB+4];
    endfunction

    function automatic phv_pkg::phv_t with_tenant(input phv_pkg::phv_t p,
                                                  input key_cfg_pkg::table_addr_t t);
        p[phv_pkg::VLAN_LSB+7:phv_pkg::VLAN_LSB+4] = t;
        return p;
    endfunction

    // immediate value, or low byte of the container given by type and index
    function automatic logic [7:0] operand_of(input phv_pkg::phv_t p, input logic imm,
                                              input logic [7:0] field);
        if (imm)
            return field;
        case (field[4:3])
            key_cfg_pkg::CONT_2B: return p.cont_2b[field[2:0]][7:0];
            key_cfg_pkg::CONT_4B: return p.cont_4b[field[2:0]][7:0];
            key_cfg_pkg::CONT_6B: return p.cont_6b[field[2:0]][7:0];
            default:              return 8'h00;
        endcase
    endfunction

    function automatic phv_pkg::key_t expected_key(input phv_pkg::phv_t p);
        key_cfg_pkg::key_offset_t off;
        phv_pkg::cmp_word_t       w;
        phv_pkg::key_t            k;
        logic [7:0]               a;
        logic [7:0]               b;
        off = ref_offset[tenant_of(p)];
        w = p.cmp[STAGE_ID];
        a = operand_of(p, w.op1_imm, w.op1);
        b = operand_of(p, w.op2_imm, w.op2);
        k = '0;
        k.f6_a = p.cont_6b[off.idx_6a];
        k.f6_b = p.cont_6b[off.idx_6b];
        k.f4_a = p.cont_4b[off.idx_4a];
        k.f4_b = p.cont_4b[off.idx_4b];
        k.f2_a = p.cont_2b[off.idx_2a];
        k.f2_b = p.cont_2b[off.idx_2b];
        case (w.opcode)
            key_cfg_pkg::CMP_GT: k.cmp[4-STAGE_ID] = (a > b);
            key_cfg_pkg::CMP_GE: k.cmp[4-STAGE_ID] = (a >= b);
            key_cfg_pkg::CMP_EQ: k.cmp[4-STAGE_ID] = (a == b);
            default:             k.cmp[4-STAGE_ID] = 1'b1;
        endcase
        return k & ~ref_mask[tenant_of(p)];
    endfunction

    task automatic check_value(input string name, input logic [CHK_W-1:0] expected,
                               input logic [CHK_W-1:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic random_phv(output phv_pkg::phv_t p);
        logic [36*32-1:0] raw;
        for (int i = 0; i < 36; i++) begin
            raw[i*32 +: 32] = $random(seed);
        end
        p = raw[CHK_W-1:0];
    endtask

    task automatic random_key(output logic [phv_pkg::KEY_W-1:0] k);
        logic [7*32-1:0] raw;
        for (int i = 0; i < 7; i++) begin
            raw[i*32 +: 32] = $random(seed);
        end
        k = raw[phv_pkg::KEY_W-1:0];
    endtask

    task automatic write_cfg(input key_cfg_pkg::table_sel_e tbl,
                             input key_cfg_pkg::table_addr_t addr,
                             input logic [phv_pkg::KEY_W-1:0] data);
        @(negedge clk);
        cfg_in = '{sel: tbl, index: addr, data: data};
        cfg_valid = 1'b1;
        @(negedge clk);
        cfg_valid = 1'b0;
        if (tbl == key_cfg_pkg::TBL_OFFSET)
            ref_offset[addr] = data[17:0];
        else
            ref_mask[addr] = data;
    endtask

    // ends on the falling edge right after the accept edge
    task automatic accept_phv(input phv_pkg::phv_t p);
        int n;
        n = 0;
        @(negedge clk);
        while (!ready_out && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!ready_out) begin
            errors++;
            $display("timeout: ready_out never rose to take a phv");
        end
        phv_in = p;
        phv_valid_in = 1'b1;
        @(negedge clk);
        phv_valid_in = 1'b0;
    endtask

    task automatic wait_pulse(output int cycles);
        cycles = 0;
        while (!phv_valid_out && cycles < LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!phv_valid_out) begin
            errors++;
            $display("timeout: no valid pulse came out of the stage");
        end
    endtask

    task automatic check_outputs(input string name, input phv_pkg::phv_t p);
        check_value({name, " phv"}, p, phv_out);
        check_value({name, " key"}, expected_key(p), key_out_masked);
        check_value({name, " mask"}, ref_mask[tenant_of(p)], key_mask_out);
        check_value({name, " key valid"}, 1'b1, key_valid_out);
        @(negedge clk);
        check_value({name, " pulse end"}, 1'b0, phv_valid_out);
    endtask

    task automatic run_phv(input string name, input phv_pkg::phv_t p);
        int cycles;
        accept_phv(p);
        wait_pulse(cycles);
        check_value({name, " latency"}, 3, cycles);
        check_outputs(name, p);
    endtask

    task automatic reset_state();
        phv_pkg::phv_t p;
        check_value("reset ready_out", 1'b1, ready_out);
        check_value("reset valids", 1'b0, phv_valid_out | key_valid_out);
        check_value("reset phv", '0, phv_out);
        check_value("reset key", '0, key_out_masked);
        check_value("reset mask", '0, key_mask_out);
        random_phv(p);
        run_phv("zero tables", p);
        check_value("zero tables 6b field", p.cont_6b[0], key_out_masked.f6_a);
        check_value("zero tables mask", '0, key_mask_out);
    endtask

    task automatic offset_lookup();
        key_cfg_pkg::table_addr_t tenants [3] = '{4'd1, 4'd6, 4'd11};
        logic [17:0]              offs [3] = '{18'o123456, 18'o701234, 18'o567012};
        phv_pkg::phv_t            p;
        for (int i = 0; i < 3; i++) begin
            write_cfg(key_cfg_pkg::TBL_OFFSET, tenants[i], offs[i]);
        end
        for (int i = 0; i < 3; i++) begin
            random_phv(p);
            p = with_tenant(p, tenants[i]);
            run_phv($sformatf("offset tenant %0d", tenants[i]), p);
            check_value("offset 6b-b field", p.cont_6b[offs[i][14:12]], key_out_masked.f6_b);
        end
    endtask

    task automatic mask_clear();
        phv_pkg::key_t             m;
        logic [phv_pkg::KEY_W-1:0] r;
        phv_pkg::phv_t             p;
        m = '0;
        m.f6_a = '1;
        m.f2_b = 16'h00ff;
        m.cmp = '1;
        write_cfg(key_cfg_pkg::TBL_MASK, 4'd6, m);
        random_key(r);
        write_cfg(key_cfg_pkg::TBL_MASK, 4'd9, r);
        random_phv(p);
        run_phv("mask tenant 6", with_tenant(p, 4'd6));
        check_value("mask 6b-a cleared", '0, key_out_masked.f6_a);
        random_phv(p);
        run_phv("mask tenant 9", with_tenant(p, 4'd9));
    endtask

    // tenant 15 keeps a zero mask so the compare bit stays visible
    task automatic compare_ops();
        logic [7:0]         v1 [3] = '{8'h05, 8'h09, 8'h07};
        logic [7:0]         v2 [3] = '{8'h09, 8'h05, 8'h07};
        phv_pkg::phv_t      p;
        phv_pkg::cmp_word_t w;
        for (int op = 0; op < 4; op++) begin
            for (int t = 0; t < 5; t++) begin
                for (int c = 0; c < 3; c++) begin
                    random_phv(p);
                    p = with_tenant(p, 4'd15);
                    p.cont_2b[3][7:0] = v1[c];
                    p.cont_4b[3][7:0] = v1[c];
                    p.cont_6b[3][7:0] = v1[c];
                    p.cont_2b[5][7:0] = v2[c];
                    p.cont_4b[5][7:0] = v2[c];
                    p.cont_6b[5][7:0] = v2[c];
                    // t of 4 stands for immediate operands
                    w.opcode = op[1:0];
                    w.op1_imm = (t == 4);
                    w.op2_imm = (t == 4);
                    w.op1 = (t == 4) ? v1[c] : {3'b000, t[1:0], 3'd3};
                    w.op2 = (t == 4) ? v2[c] : {3'b000, t[1:0], 3'd5};
                    p.cmp[STAGE_ID] = w;
                    run_phv($sformatf("compare op%0d type%0d case%0d", op, t, c), p);
                    check_value("compare other bits", '0, key_out_masked.cmp & 5'b11011);
                end
            end
        end
    endtask

    task automatic backpressure();
        phv_pkg::phv_t p;
        phv_pkg::phv_t other;
        int            hold;
        int            cycles;
        random_phv(p);
        random_phv(other);
        hold = 4 + ($random(seed) & 7);
        ready_in = 1'b0;
        accept_phv(p);
        // offered while busy, must be dropped
        phv_in = other;
        phv_valid_in = 1'b1;
        for (int i = 0; i < hold; i++) begin
            check_value("backpressure valids", 1'b0, phv_valid_out | key_valid_out);
            check_value("backpressure ready_out", 1'b0, ready_out);
            @(negedge clk);
        end
        phv_valid_in = 1'b0;
        ready_in = 1'b1;
        wait_pulse(cycles);
        check_value("backpressure release latency", 1, cycles);
        check_outputs("backpressure", p);
        repeat (6) begin
            @(negedge clk);
            check_value("backpressure extra pulse", 1'b0, phv_valid_out);
        end
    endtask

    task automatic random_traffic();
        phv_pkg::phv_t             p;
        logic [phv_pkg::KEY_W-1:0] d;
        int                        n;
        int                        r;
        for (int i = 0; i < 40; i++) begin
            n = $random(seed) & 3;
            for (int j = 0; j < n; j++) begin
                random_key(d);
                r = $random(seed);
                write_cfg(key_cfg_pkg::table_sel_e'(r[0]), r[4:1], d);
            end
            random_phv(p);
            run_phv($sformatf("random %0d", i), p);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        phv_in = '0;
        phv_valid_in = 1'b0;
        cfg_valid = 1'b0;
        cfg_in = '0;
        ready_in = 1'b1;
        for (int i = 0; i < key_cfg_pkg::TABLE_DEPTH; i++) begin
            ref_offset[i] = '0;
            ref_mask[i] = '0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        reset_state();
        offset_lookup();
        mask_clear();
        compare_ops();
        backpressure();
        random_traffic();
        @(negedge clk);
        $display("errors: %0d, assertion failures: %0d", errors,
                 UUT.u_key_extract_assert.fail_count);
        if (errors == 0 && UUT.u_key_extract_assert.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
hdl/phv_pkg.sv
hdl/key_cfg_pkg.sv
hdl/phv_capture.sv
hdl/key_config_tables.sv
hdl/key_compare.sv
hdl/key_output_stage.sv
hdl/key_extract.sv
dv/key_extract_assert.sv
dv/key_extract_tb.sv

/* hdl/key_cfg_pkg.sv */
// key config package: tenant table geometry, config write format and opcode encodings
package key_cfg_pkg;

    localparam int TABLE_DEPTH = 16;
    localparam int IDX_W       = $clog2(phv_pkg::NUM_CONT);

    typedef logic [$clog2(TABLE_DEPTH)-1:0] table_addr_t;

    // container index per key field, in key order
    typedef struct packed {
        logic [IDX_W-1:0] idx_6a;
        logic [IDX_W-1:0] idx_6b;
        logic [IDX_W-1:0] idx_4a;
        logic [IDX_W-1:0] idx_4b;
        logic [IDX_W-1:0] idx_2a;
        logic [IDX_W-1:0] idx_2b;
    } key_offset_t;

    // value 3 is reserved, the operand reads as zero
    typedef enum logic [1:0] {
        CONT_2B = 2'd0,
        CONT_4B = 2'd1,
        CONT_6B = 2'd2
    } cont_type_e;

    typedef enum logic [1:0] {
        CMP_GT   = 2'd0,
        CMP_GE   = 2'd1,
        CMP_EQ   = 2'd2,
        CMP_TRUE = 2'd3
    } cmp_opcode_e;

    typedef enum logic {
        TBL_OFFSET = 1'b0,
        TBL_MASK   = 1'b1
    } table_sel_e;

    // offset writes take the low bits of data
    typedef struct packed {
        table_sel_e                sel;
        table_addr_t               index;
        logic [phv_pkg::KEY_W-1:0] data;
    } cfg_write_t;

endpackage

/* hdl/key_compare.sv */
// key compare: picks the two comparator operands and registers the unsigned compare bit
`timescale 1ns/100ps

module key_compare (
    input  logic                 clk,
    input  logic                 rst_n,
    input  phv_pkg::containers_t cont,
    input  phv_pkg::cmp_word_t   cmp_word,
    output logic                 cmp_bit
);

    logic [7:0] opnd_1;
    logic [7:0] opnd_2;
    logic       cmp_next;

    // immediate, or low byte of the container named by type and index
    function automatic logic [7:0] sel_operand(
        input logic                 imm,
        input logic [7:0]           field,
        input phv_pkg::containers_t c
    );
        logic [key_cfg_pkg::IDX_W-1:0] idx;
        logic [7:0]                    val;
        idx = field[key_cfg_pkg::IDX_W-1:0];
        if (imm) begin
            val = field;
        end else begin
            case (key_cfg_pkg::cont_type_e'(field[4:3]))
                key_cfg_pkg::CONT_2B: val = c.c2[idx][7:0];
                key_cfg_pkg::CONT_4B: val = c.c4[idx][7:0];
                key_cfg_pkg::CONT_6B: val = c.c6[idx][7:0];
                default:              val = 8'h00;
            endcase
        end
        return val;
    endfunction

    always_comb begin
        opnd_1 = sel_operand(cmp_word.op1_imm, cmp_word.op1, cont);
        opnd_2 = sel_operand(cmp_word.op2_imm, cmp_word.op2, cont);
        case (key_cfg_pkg::cmp_opcode_e'(cmp_word.opcode))
            key_cfg_pkg::CMP_GT:   cmp_next = (opnd_1 > opnd_2);
            key_cfg_pkg::CMP_GE:   cmp_next = (opnd_1 >= opnd_2);
            key_cfg_pkg::CMP_EQ:   cmp_next = (opnd_1 == opnd_2);
            key_cfg_pkg::CMP_TRUE: cmp_next = 1'b1;
        endcase
    end

    // ready one cycle after the captured phv settles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmp_bit <= 1'b0;
        end else begin
            cmp_bit <= cmp_next;
        end
    end

endmodule

/* hdl/key_config_tables.sv */
// key config tables: per-tenant offset and mask entries with a registered lookup
`timescale 1ns/100ps

module key_config_tables (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_valid,
    input  key_cfg_pkg::cfg_write_t  cfg_in,
    input  key_cfg_pkg::table_addr_t table_addr,
    output key_cfg_pkg::key_offset_t key_offset,
    output phv_pkg::key_t            key_mask
);

    localparam int OFF_W = $bits(key_cfg_pkg::key_offset_t);

    key_cfg_pkg::key_offset_t offset_tbl [key_cfg_pkg::TABLE_DEPTH];
    phv_pkg::key_t            mask_tbl   [key_cfg_pkg::TABLE_DEPTH];
    key_cfg_pkg::key_offset_t off_data;

    assign off_data = cfg_in.data[OFF_W-1:0];

    // write port, one entry per strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < key_cfg_pkg::TABLE_DEPTH; i++) begin
                offset_tbl[i] <= '0;
                mask_tbl[i]   <= '0;
            end
        end else if (cfg_valid) begin
            case (cfg_in.sel)
                key_cfg_pkg::TBL_OFFSET: offset_tbl[cfg_in.index] <= off_data;
                key_cfg_pkg::TBL_MASK:   mask_tbl[cfg_in.index]   <= cfg_in.data;
            endcase
        end
    end

    // lookup follows the captured tenant every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_offset <= '0;
            key_mask   <= '0;
        end else begin
            key_offset <= offset_tbl[table_addr];
            key_mask   <= mask_tbl[table_addr];
        end
    end

endmodule

/* hdl/key_extract.sv */
// key extract: match-action stage that builds the masked lookup key from a phv
`timescale 1ns/100ps

module key_extract #(
    parameter int STAGE_ID = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  phv_pkg::phv_t           phv_in,
    input  logic                    phv_valid_in,
    output logic                    ready_out,
    input  logic                    cfg_valid,
    input  key_cfg_pkg::cfg_write_t cfg_in,
    output phv_pkg::phv_t           phv_out,
    output logic                    phv_valid_out,
    output phv_pkg::key_t           key_out_masked,
    output phv_pkg::key_t           key_mask_out,
    output logic                    key_valid_out,
    input  logic                    ready_in
);

    phv_pkg::phv_t            phv_q;
    phv_pkg::containers_t     cont;
    phv_pkg::cmp_word_t       cmp_word;
    key_cfg_pkg::table_addr_t table_addr;
    key_cfg_pkg::key_offset_t key_offset;
    phv_pkg::key_t            key_mask;
    logic                     load;
    logic                     cmp_bit;

    phv_capture #(
        .STAGE_ID (STAGE_ID)
    ) u_phv_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .phv_in     (phv_in),
        .phv_q      (phv_q),
        .cont       (cont),
        .table_addr (table_addr),
        .cmp_word   (cmp_word)
    );

    key_config_tables u_key_config_tables (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_valid  (cfg_valid),
        .cfg_in     (cfg_in),
        .table_addr (table_addr),
        .key_offset (key_offset),
        .key_mask   (key_mask)
    );

    key_compare u_key_compare (
        .clk      (clk),
        .rst_n    (rst_n),
        .cont     (cont),
        .cmp_word (cmp_word),
        .cmp_bit  (cmp_bit)
    );

    key_output_stage #(
        .STAGE_ID (STAGE_ID)
    ) u_key_output_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_valid_in   (phv_valid_in),
        .ready_in       (ready_in),
        .phv_q          (phv_q),
        .cont           (cont),
        .key_offset     (key_offset),
        .key_mask       (key_mask),
        .cmp_bit        (cmp_bit),
        .load           (load),
        .ready_out      (ready_out),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_out_masked (key_out_masked),
        .key_mask_out   (key_mask_out),
        .key_valid_out  (key_valid_out)
    );

endmodule

/* hdl/key_output_stage.sv */
// key output stage: sequencing fsm, key assembly and masking, handshake to the next stage
`timescale 1ns/100ps

module key_output_stage #(
    parameter int STAGE_ID = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     phv_valid_in,
    input  logic                     ready_in,
    input  phv_pkg::phv_t            phv_q,
    input  phv_pkg::containers_t     cont,
    input  key_cfg_pkg::key_offset_t key_offset,
    input  phv_pkg::key_t            key_mask,
    input  logic                     cmp_bit,
    output logic                     load,
    output logic                     ready_out,
    output phv_pkg::phv_t            phv_out,
    output logic                     phv_valid_out,
    output phv_pkg::key_t            key_out_masked,
    output phv_pkg::key_t            key_mask_out,
    output logic                     key_valid_out
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        ASSEMBLE,
        DECIDE,
        HOLD
    } state_e;

    state_e        state;
    state_e        state_next;
    phv_pkg::key_t key_raw;
    logic          out_valid;
    logic          release_out;

    // take a new phv only while nothing is in flight
    assign ready_out = (state == IDLE);
    assign load      = ready_out && phv_valid_in;

    // result leaves once the next stage can take it
    assign release_out = ((state == DECIDE) || (state == HOLD)) && ready_in;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (load) begin
                    state_next = LOOKUP;
                end
            end
            // tables and comparator register their results here
            LOOKUP:   state_next = ASSEMBLE;
            ASSEMBLE: state_next = DECIDE;
            DECIDE:   state_next = release_out ? IDLE : HOLD;
            HOLD:     state_next = release_out ? IDLE : HOLD;
            default:  state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // key fields from the tenant's container indices
    always_comb begin
        key_raw      = '0;
        key_raw.f6_a = cont.c6[key_offset.idx_6a];
        key_raw.f6_b = cont.c6[key_offset.idx_6b];
        key_raw.f4_a = cont.c4[key_offset.idx_4a];
        key_raw.f4_b = cont.c4[key_offset.idx_4b];
        key_raw.f2_a = cont.c2[key_offset.idx_2a];
        key_raw.f2_b = cont.c2[key_offset.idx_2b];
        key_raw.cmp[phv_pkg::NUM_CMP-1-STAGE_ID] = cmp_bit;
    end

    // outputs stay put while waiting on ready_in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_out        <= '0;
            key_out_masked <= '0;
            key_mask_out   <= '0;
        end else if (state == ASSEMBLE) begin
            phv_out        <= phv_q;
            key_out_masked <= key_raw & ~key_mask;
            key_mask_out   <= key_mask;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= release_out;
        end
    end

    // phv and key leave together
    assign phv_valid_out = out_valid;
    assign key_valid_out = out_valid;

endmodule

/* hdl/phv_capture.sv */
// phv capture: holds the accepted phv and splits out containers, tenant and comparator
`timescale 1ns/100ps

module phv_capture #(
    parameter int STAGE_ID = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  phv_pkg::phv_t            phv_in,
    output phv_pkg::phv_t            phv_q,
    output phv_pkg::containers_t     cont,
    output key_cfg_pkg::table_addr_t table_addr,
    output phv_pkg::cmp_word_t       cmp_word
);

    logic [phv_pkg::VLAN_MSB-phv_pkg::VLAN_LSB:0] vlan_id;

    // only one phv in flight, load comes once per accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_q <= '0;
        end else if (load) begin
            phv_q <= phv_in;
        end
    end

    // container views keep phv order, index 7 is the top one
    assign cont = {phv_q.cont_6b, phv_q.cont_4b, phv_q.cont_2b};

    assign vlan_id = phv_q[phv_pkg::VLAN_MSB:phv_pkg::VLAN_LSB];

    // tenant index
    assign table_addr = vlan_id[7:4];

    // each stage runs only its own comparator word
    assign cmp_word = phv_q.cmp[STAGE_ID];

endmodule

/* hdl/phv_pkg.sv */
// phv layout package: header vector, container views, comparator word and key format
package phv_pkg;

    // container widths per size class
    localparam int W_2B = 16;
    localparam int W_4B = 32;
    localparam int W_6B = 48;

    localparam int NUM_CONT = 8;
    localparam int NUM_CMP  = 5;

    // two fields per size class plus one compare bit per stage
    localparam int KEY_W = 2 * W_6B + 2 * W_4B + 2 * W_2B + NUM_CMP;

    // vlan id inside the metadata, bits 7:4 of it pick the tenant
    localparam int VLAN_LSB = 129;
    localparam int VLAN_MSB = 140;

    typedef struct packed {
        logic [1:0] opcode;
        logic       op1_imm;
        logic [7:0] op1;
        logic       op2_imm;
        logic [7:0] op2;
    } cmp_word_t;

    // word 0 of cmp sits at the top, phv bits 355:336
    typedef struct packed {
        logic [NUM_CONT-1:0][W_6B-1:0] cont_6b;
        logic [NUM_CONT-1:0][W_4B-1:0] cont_4b;
        logic [NUM_CONT-1:0][W_2B-1:0] cont_2b;
        cmp_word_t [0:NUM_CMP-1]       cmp;
        logic [255:0]                  meta;
    } phv_t;

    typedef struct packed {
        logic [NUM_CONT-1:0][W_6B-1:0] c6;
        logic [NUM_CONT-1:0][W_4B-1:0] c4;
        logic [NUM_CONT-1:0][W_2B-1:0] c2;
    } containers_t;

    // compare bit 4 belongs to stage 0
    typedef struct packed {
        logic [W_6B-1:0]    f6_a;
        logic [W_6B-1:0]    f6_b;
        logic [W_4B-1:0]    f4_a;
        logic [W_4B-1:0]    f4_b;
        logic [W_2B-1:0]    f2_a;
        logic [W_2B-1:0]    f2_b;
        logic [NUM_CMP-1:0] cmp;
    } key_t;

endpackage
